// File: project.f
rtl/mem_bus_pkg.sv
rtl/mem_bank_pkg.sv
rtl/rr_arbiter.sv
rtl/mem_latency_timer.sv
rtl/mem_bank_ram.sv
rtl/mem_bank_ctrl.sv
rtl/mem_arb.sv
rtl/mem_subsys_top.sv
verification/mem_subsys_props.sv
verification/mem_subsys_tb.sv

// File: rtl/mem_arb.sv
`timescale 1ns/10ps

module mem_arb #(
    parameter int NUM_REQUESTS = 3
) (
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  logic [NUM_REQUESTS-1:0]                    core_req_valid,
    input  mem_bus_pkg::core_req_t [NUM_REQUESTS-1:0]  core_req,
    output logic [NUM_REQUESTS-1:0]                    core_req_ready,

    output logic [NUM_REQUESTS-1:0]                    core_rsp_valid,
    output mem_bus_pkg::core_rsp_t [NUM_REQUESTS-1:0]  core_rsp,
    input  logic [NUM_REQUESTS-1:0]                    core_rsp_ready,

    output logic                                       mem_req_valid,
    output mem_bus_pkg::mem_req_t                      mem_req,
    input  logic                                       mem_req_ready,

    input  logic                                       mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t                      mem_rsp,
    output logic                                       mem_rsp_ready
);
    localparam int IDX_W = mem_bus_pkg::MAX_REQS_BITS;

    logic [NUM_REQUESTS-1:0] grant_onehot;
    logic [IDX_W-1:0]        grant_index;
    logic                    stall;
    logic                    any_req;
    mem_bus_pkg::core_req_t  sel_req;
    logic [IDX_W-1:0]        rsp_sel;

    assign stall   = mem_req_valid && !mem_req_ready;
    assign any_req = |core_req_valid;
    assign sel_req = core_req[grant_index];

    rr_arbiter #(
        .NUM_REQUESTS (NUM_REQUESTS)
    ) u_rr_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .requests     (core_req_valid),
        .advance      (any_req && !stall),
        .grant_onehot (grant_onehot),
        .grant_index  (grant_index)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
        end else if (!stall) begin
            mem_req_valid <= any_req;
        end
    end

    // Held while the bank is not ready.
    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_req.tag    <= {sel_req.tag, grant_index};  // Index in the low bits.
            mem_req.addr   <= sel_req.addr;
            mem_req.rw     <= sel_req.rw;
            mem_req.byteen <= sel_req.byteen;
            mem_req.data   <= sel_req.data;
        end
    end

    assign rsp_sel = mem_rsp.tag[IDX_W-1:0];

    for (genvar i = 0; i < NUM_REQUESTS; i++) begin : g_port
        assign core_req_ready[i] = grant_onehot[i] && !stall;
        assign core_rsp_valid[i] = mem_rsp_valid && (rsp_sel == IDX_W'(i));
        assign core_rsp[i]       = '{
            tag:  mem_rsp.tag[IDX_W +: mem_bus_pkg::TAG_IN_WIDTH],
            data: mem_rsp.data
        };
    end

    assign mem_rsp_ready = core_rsp_ready[rsp_sel];

endmodule

// File: rtl/mem_bank_ctrl.sv
`timescale 1ns/10ps

module mem_bank_ctrl #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req_valid,
    input  mem_bus_pkg::mem_req_t mem_req,
    output logic                  mem_req_ready,
    output logic                  mem_rsp_valid,
    output mem_bus_pkg::mem_rsp_t mem_rsp,
    input  logic                  mem_rsp_ready
);
    localparam mem_bank_pkg::lat_cnt_t LOAD_VALUE = mem_bank_pkg::lat_cnt_t'(MEM_LATENCY - 1);

    mem_bank_pkg::bank_state_t state;
    mem_bank_pkg::bank_state_t state_next;
    mem_bus_pkg::tag_out_t     pend_tag;
    mem_bus_pkg::data_t        ram_rdata;
    logic                      req_fire;
    logic                      ram_we;
    logic                      ram_re;
    logic                      timer_done;

    assign mem_req_ready = (state == mem_bank_pkg::BANK_IDLE);
    assign req_fire      = mem_req_valid && mem_req_ready;
    assign ram_we        = req_fire && mem_req.rw;
    assign ram_re        = req_fire && !mem_req.rw;

    always_comb begin
        state_next = state;
        case (state)
            mem_bank_pkg::BANK_IDLE: if (ram_re) state_next = mem_bank_pkg::BANK_WAIT;
            mem_bank_pkg::BANK_WAIT: if (timer_done) state_next = mem_bank_pkg::BANK_RESP;
            mem_bank_pkg::BANK_RESP: if (mem_rsp_ready) state_next = mem_bank_pkg::BANK_IDLE;
            default:                 state_next = mem_bank_pkg::BANK_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_bank_pkg::BANK_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_re) begin
            pend_tag <= mem_req.tag;
        end
    end

    mem_latency_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (ram_re),
        .load_value (LOAD_VALUE),
        .done       (timer_done)
    );

    mem_bank_ram u_ram (
        .clk        (clk),
        .write_en   (ram_we),
        .read_en    (ram_re),
        .addr       (mem_req.addr),
        .byteen     (mem_req.byteen),
        .write_data (mem_req.data),
        .read_data  (ram_rdata)
    );

    assign mem_rsp_valid = (state == mem_bank_pkg::BANK_RESP);
    assign mem_rsp       = '{tag: pend_tag, data: ram_rdata};  // Data held by the RAM.

endmodule

// File: rtl/mem_bank_pkg.sv
package mem_bank_pkg;

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_WAIT,  // Latency timer running.
        BANK_RESP   // Read data presented on the response link.
    } bank_state_t;

    localparam int TIMER_WIDTH = 4;

    typedef logic [TIMER_WIDTH-1:0] lat_cnt_t;

endpackage

// File: rtl/mem_bank_ram.sv
`timescale 1ns/10ps

module mem_bank_ram (
    input  logic                 clk,
    input  logic                 write_en,
    input  logic                 read_en,
    input  mem_bus_pkg::addr_t   addr,
    input  mem_bus_pkg::byteen_t byteen,
    input  mem_bus_pkg::data_t   write_data,
    output mem_bus_pkg::data_t   read_data
);
    localparam int NUM_WORDS = 2 ** mem_bus_pkg::ADDR_WIDTH;
    localparam int NUM_BYTES = $bits(mem_bus_pkg::byteen_t);

    mem_bus_pkg::data_t mem [NUM_WORDS];

    always_ff @(posedge clk) begin
        if (write_en) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (byteen[b]) begin
                    mem[addr][b*8 +: 8] <= write_data[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, held until the next read.
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[addr];
        end
    end

endmodule

// File: rtl/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 8;  // 256 words.
    localparam int TAG_IN_WIDTH  = 4;
    localparam int MAX_REQS_BITS = 2;  // Up to 4 requesters.

    typedef logic [DATA_WIDTH-1:0]                   data_t;
    typedef logic [ADDR_WIDTH-1:0]                   addr_t;
    typedef logic [DATA_WIDTH/8-1:0]                 byteen_t;
    typedef logic [TAG_IN_WIDTH-1:0]                 tag_in_t;
    typedef logic [TAG_IN_WIDTH+MAX_REQS_BITS-1:0]   tag_out_t;  // {tag, index}.

    typedef struct packed {
        tag_in_t tag;
        addr_t   addr;
        logic    rw;      // 1 is a write.
        byteen_t byteen;
        data_t   data;
    } core_req_t;

    typedef struct packed {
        tag_out_t tag;
        addr_t    addr;
        logic     rw;
        byteen_t  byteen;
        data_t    data;
    } mem_req_t;

    typedef struct packed {
        tag_in_t tag;
        data_t   data;
    } core_rsp_t;

    typedef struct packed {
        tag_out_t tag;
        data_t    data;
    } mem_rsp_t;

endpackage

// File: rtl/mem_latency_timer.sv
`timescale 1ns/10ps

module mem_latency_timer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  mem_bank_pkg::lat_cnt_t load_value,
    output logic                   done
);
    mem_bank_pkg::lat_cnt_t count;
    logic                   armed;

    assign done = armed && (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            armed <= 1'b0;
        end else if (load) begin
            count <= load_value;
            armed <= 1'b1;
        end else if (done) begin
            armed <= 1'b0;  // One pulse per load.
        end else if (armed) begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: rtl/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top #(
    parameter int NUM_REQUESTS = 3,
    parameter int MEM_LATENCY  = 3
) (
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  logic [NUM_REQUESTS-1:0]                    core_req_valid,
    input  mem_bus_pkg::core_req_t [NUM_REQUESTS-1:0]  core_req,
    output logic [NUM_REQUESTS-1:0]                    core_req_ready,

    output logic [NUM_REQUESTS-1:0]                    core_rsp_valid,
    output mem_bus_pkg::core_rsp_t [NUM_REQUESTS-1:0]  core_rsp,
    input  logic [NUM_REQUESTS-1:0]                    core_rsp_ready
);
    logic                  mem_req_valid;
    mem_bus_pkg::mem_req_t mem_req;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    mem_bus_pkg::mem_rsp_t mem_rsp;
    logic                  mem_rsp_ready;

    mem_arb #(
        .NUM_REQUESTS (NUM_REQUESTS)
    ) u_mem_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    mem_bank_ctrl #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem_bank_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

endmodule

// File: rtl/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int NUM_REQUESTS = 3
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [NUM_REQUESTS-1:0]               requests,
    input  logic                                  advance,
    output logic [NUM_REQUESTS-1:0]               grant_onehot,
    output logic [mem_bus_pkg::MAX_REQS_BITS-1:0] grant_index
);
    localparam int IDX_W = mem_bus_pkg::MAX_REQS_BITS;

    logic [IDX_W-1:0] prio_ptr;

    // Scan from the far end so the slot nearest the pointer wins.
    always_comb begin
        int slot;
        grant_onehot = '0;
        grant_index  = '0;
        slot         = 0;
        for (int k = NUM_REQUESTS - 1; k >= 0; k--) begin
            slot = (int'(prio_ptr) + k) % NUM_REQUESTS;
            if (requests[slot]) begin
                grant_onehot       = '0;
                grant_onehot[slot] = 1'b1;
                grant_index        = slot[IDX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_ptr <= '0;
        end else if (advance) begin
            if (grant_index == IDX_W'(NUM_REQUESTS - 1)) begin
                prio_ptr <= '0;  // Wrap.
            end else begin
                prio_ptr <= grant_index + 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb \
    -f project.f -o mem_subsys_sim

out=$(./obj_dir/mem_subsys_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx '>>> PASS'

// File: verification/mem_subsys_props.sv
`timescale 1ns/10ps

module mem_subsys_props #(
    parameter int NUM_REQUESTS = 3
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    mem_req_valid,
    input mem_bus_pkg::mem_req_t   mem_req,
    input logic                    mem_req_ready,
    input logic                    mem_rsp_valid,
    input mem_bus_pkg::mem_rsp_t   mem_rsp,
    input logic                    mem_rsp_ready,
    input logic [NUM_REQUESTS-1:0] core_rsp_valid
);
    logic read_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_pending <= 1'b0;
        end else if (mem_req_valid && mem_req_ready && !mem_req.rw) begin
            read_pending <= 1'b1;  // Read taken by the bank.
        end else if (mem_rsp_valid && mem_rsp_ready) begin
            read_pending <= 1'b0;
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed while stalled");

    rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid && !mem_rsp_ready |=> mem_rsp_valid && $stable(mem_rsp))
        else $error("mem_rsp changed while stalled");

    rsp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(core_rsp_valid))
        else $error("more than one core_rsp_valid high");

    busy_bank: assert property (@(posedge clk) disable iff (!rst_n)
        read_pending |-> !mem_req_ready)
        else $error("mem_req_ready high with a read pending");

endmodule

bind mem_subsys_top mem_subsys_props #(
    .NUM_REQUESTS (NUM_REQUESTS)
) u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp        (mem_rsp),
    .mem_rsp_ready  (mem_rsp_ready),
    .core_rsp_valid (core_rsp_valid)
);

// File: verification/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb;
    localparam int NUM_REQ     = 3;
    localparam int MEM_LATENCY = 3;
    localparam int RAND_PAIRS  = 8;  // Writes, then reads of the same words, per port.
    localparam int NUM_TXN     = 256 + NUM_REQ * RAND_PAIRS * 2 + 4 + NUM_REQ * 2;
    localparam int TIMEOUT     = 20 * NUM_TXN + 200;

    logic                                 clk;
    logic                                 rst_n;
    logic [NUM_REQ-1:0]                   core_req_valid;
    mem_bus_pkg::core_req_t [NUM_REQ-1:0] core_req;
    logic [NUM_REQ-1:0]                   core_req_ready;
    logic [NUM_REQ-1:0]                   core_rsp_valid;
    mem_bus_pkg::core_rsp_t [NUM_REQ-1:0] core_rsp;
    logic [NUM_REQ-1:0]                   core_rsp_ready;

    mem_bus_pkg::core_req_t               req_q [NUM_REQ][$];
    mem_bus_pkg::core_rsp_t               exp_q [NUM_REQ][$];  // Outstanding reads.
    mem_bus_pkg::data_t                   model [256];
    int                                   acc_cycle [NUM_REQ];
    logic [31:0]                          lcg_state = 32'hc20c9d84;
    int                                   cycle = 0;
    int                                   errors = 0;
    int                                   checks = 0;
    int                                   open_reads = 0;
    int                                   last_port = -1;
    int                                   hold_accepts = 0;
    bit                                   rr_mode = 1'b0;
    bit                                   iso_mode = 1'b0;
    logic [NUM_REQ-1:0]                   held_prev = '0;
    mem_bus_pkg::core_rsp_t [NUM_REQ-1:0] held_rsp;

    mem_subsys_top #(.NUM_REQUESTS (NUM_REQ), .MEM_LATENCY (MEM_LATENCY)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Byte-enable merge. With no enables it returns the stored word.
    function automatic mem_bus_pkg::data_t merge_word(input mem_bus_pkg::data_t old_word,
            input mem_bus_pkg::data_t new_word, input mem_bus_pkg::byteen_t be);
        mem_bus_pkg::data_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected 0x%0h, got 0x%0h at cycle %0d",
                     name, expected, actual, cycle);
        end
    endtask

    task automatic report_and_finish();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic push_req(input int port, input logic rw, input mem_bus_pkg::addr_t addr,
                            input mem_bus_pkg::byteen_t be, input mem_bus_pkg::data_t data);
        mem_bus_pkg::core_req_t r;
        r.tag    = mem_bus_pkg::tag_in_t'(lcg_next() >> 28);
        r.addr   = addr;
        r.rw     = rw;
        r.byteen = be;
        r.data   = data;
        req_q[port].push_back(r);
    endtask

    // One clock. The head of each queue stays on the port until it is accepted.
    task automatic run_cycle();
        logic [NUM_REQ-1:0] fired;
        @(posedge clk);
        fired = core_req_valid & core_req_ready;
        @(negedge clk);
        for (int i = 0; i < NUM_REQ; i++) begin
            if (fired[i]) begin
                void'(req_q[i].pop_front());
            end
            core_req_valid[i] = (req_q[i].size() != 0);
            if (req_q[i].size() != 0) begin
                core_req[i] = req_q[i][0];
            end
        end
    endtask

    task automatic drain();
        do begin
            run_cycle();
        end while (core_req_valid != '0 || open_reads != 0);
    endtask

    initial begin
        mem_bus_pkg::addr_t addrs [RAND_PAIRS];
        mem_bus_pkg::addr_t fa;
        rst_n          = 1'b0;
        core_req_valid = '0;
        core_req       = '0;
        core_rsp_ready = '1;
        for (int c = 0; c < 6; c++) begin  // 4 cycles in reset, 2 after.
            @(negedge clk);
            check("core_req_ready", 0, core_req_ready);
            check("core_rsp_valid", 0, core_rsp_valid);
            if (c == 3) begin
                rst_n = 1'b1;
            end
        end
        for (int a = 0; a < 256; a++) begin
            fa = mem_bus_pkg::addr_t'(a);
            push_req(0, 1'b1, fa, 4'hf, {fa, ~fa, fa ^ 8'h5a, fa + 8'h3c});
        end
        drain();
        rr_mode   = 1'b1;
        last_port = -1;
        for (int i = 0; i < NUM_REQ; i++) begin
            for (int k = 0; k < RAND_PAIRS; k++) begin
                addrs[k] = mem_bus_pkg::addr_t'(lcg_next() >> 24);
                push_req(i, 1'b1, addrs[k], mem_bus_pkg::byteen_t'(lcg_next() >> 28), lcg_next());
            end
            for (int k = 0; k < RAND_PAIRS; k++) begin
                push_req(i, 1'b0, addrs[k], '0, '0);
            end
        end
        drain();
        rr_mode  = 1'b0;
        iso_mode = 1'b1;
        for (int j = 0; j < 4; j++) begin
            push_req(j % NUM_REQ, 1'b0, mem_bus_pkg::addr_t'(lcg_next() >> 24), '0, '0);
            drain();
        end
        iso_mode          = 1'b0;
        core_rsp_ready[1] = 1'b0;  // Back-pressure on port 1.
        for (int i = 0; i < NUM_REQ * 2; i++) begin
            push_req(i % NUM_REQ, 1'b0, mem_bus_pkg::addr_t'(lcg_next() >> 24), '0, '0);
        end
        while (!core_rsp_valid[1]) begin
            run_cycle();
        end
        repeat (8) run_cycle();
        core_rsp_ready[1] = 1'b1;
        drain();
        repeat (2) run_cycle();
        report_and_finish();
    end

    always @(posedge clk) begin
        logic [NUM_REQ-1:0]     held_now;
        mem_bus_pkg::core_req_t req;
        mem_bus_pkg::core_rsp_t exp_rsp;
        cycle++;
        held_now = core_rsp_valid & ~core_rsp_ready;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (held_prev[i]) begin
                check("core_rsp_valid", 1, core_rsp_valid[i]);
                check("core_rsp", held_rsp[i], core_rsp[i]);
            end
            held_rsp[i] = core_rsp[i];
            if (core_rsp_valid[i] && core_rsp_ready[i]) begin
                if (exp_q[i].size() == 0) begin
                    $display("ERROR: response on port %0d with no read outstanding", i);
                    errors++;
                end else begin
                    exp_rsp = exp_q[i].pop_front();
                    open_reads--;
                    check("core_rsp.tag", exp_rsp.tag, core_rsp[i].tag);
                    check("core_rsp.data", exp_rsp.data, core_rsp[i].data);
                    if (iso_mode) begin
                        // Valid rises LATENCY+1 after the accept and is seen one edge later.
                        check("rsp_latency", MEM_LATENCY + 2, cycle - acc_cycle[i]);
                    end
                end
            end
        end
        held_prev = held_now;
        if (held_now == '0) begin
            hold_accepts = 0;
        end else if (hold_accepts != 0) begin
            check("core_req_ready", 0, core_req_ready);  // Stage full, bank blocked.
        end
        for (int i = 0; i < NUM_REQ; i++) begin
            if (core_req_valid[i] && core_req_ready[i]) begin
                req = core_req[i];
                if (rr_mode && last_port >= 0) begin
                    check("accept_port", (last_port + 1) % NUM_REQ, i);
                end
                last_port    = i;
                acc_cycle[i] = cycle;
                hold_accepts += (held_now != '0);
                if (req.rw) begin
                    model[req.addr] = merge_word(model[req.addr], req.data, req.byteen);
                end else begin
                    exp_rsp.tag  = req.tag;
                    exp_rsp.data = merge_word(model[req.addr], '0, '0);
                    exp_q[i].push_back(exp_rsp);
                    open_reads++;
                end
            end
        end
        if (cycle >= TIMEOUT) begin
            $display("ERROR: timeout after %0d cycles with traffic still pending", cycle);
            errors++;
            report_and_finish();
        end
    end

endmodule
